// ==== bench/rv_ref_model.svh ====
// Reference decode, stage projection and load-use functions for the control path testbench
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Shared by OP and OP-IMM, SUB only exists in the register form
function automatic rv_pkg::alu_op_e arith_op(logic [2:0] f3, logic alt, logic is_reg);
    case (f3)
        3'd0:    return (is_reg && alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
        3'd1:    return rv_pkg::ALU_SLL;
        3'd2:    return rv_pkg::ALU_SLT;
        3'd3:    return rv_pkg::ALU_SLTU;
        3'd4:    return rv_pkg::ALU_XOR;
        3'd5:    return alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
        3'd6:    return rv_pkg::ALU_OR;
        default: return rv_pkg::ALU_AND;
    endcase
endfunction

function automatic rv_pkg::id_ctrl_t ref_decode(logic [31:0] w);
    rv_pkg::id_ctrl_t c;
    logic [6:0]       op;
    logic [2:0]       f3;
    logic             ok;
    c  = '0;
    op = w[6:0];
    f3 = w[14:12];
    ok = 1'b1;
    if (w == 32'h0) begin
        return c;   // All-zero word is a plain empty bundle
    end
    case (op)
        rv_pkg::OPC_R, rv_pkg::OPC_I: begin
            c.alu_op   = arith_op(f3, w[30], op == rv_pkg::OPC_R);
            c.imm_kind = (op == rv_pkg::OPC_I) ? rv_pkg::IMM_I : rv_pkg::IMM_NONE;
            c.wb.we    = 1'b1;
            c.rs1_used = 1'b1;
            c.rs2_used = (op == rv_pkg::OPC_R);
        end
        rv_pkg::OPC_LOAD: begin
            ok         = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            c.alu_op   = rv_pkg::ALU_ADD;
            c.imm_kind = rv_pkg::IMM_I;
            c.mem.en   = 1'b1;
            c.mem.load = 1'b1;
            c.mem.size = rv_pkg::mem_size_e'(f3[1:0]);
            c.mem.sext = (f3 == 3'd0) || (f3 == 3'd1);
            c.wb.we    = 1'b1;
            c.rs1_used = 1'b1;
        end
        rv_pkg::OPC_STORE: begin
            ok          = (f3 < 3'd3);
            c.alu_op    = rv_pkg::ALU_ADD;
            c.imm_kind  = rv_pkg::IMM_S;
            c.mem.en    = 1'b1;
            c.mem.write = 1'b1;
            c.mem.size  = rv_pkg::mem_size_e'(f3[1:0]);
            c.rs1_used  = 1'b1;
            c.rs2_used  = 1'b1;
        end
        rv_pkg::OPC_BRANCH: begin
            c.rs1_used = 1'b1;
            c.rs2_used = 1'b1;
            c.alu_op   = !f3[2] ? rv_pkg::ALU_SUB : (f3[1] ? rv_pkg::ALU_SLTU : rv_pkg::ALU_SLT);
            case (f3)
                3'd0:    c.branch = rv_pkg::BR_EQ;
                3'd1:    c.branch = rv_pkg::BR_NE;
                3'd4:    c.branch = rv_pkg::BR_LT;
                3'd5:    c.branch = rv_pkg::BR_GE;
                3'd6:    c.branch = rv_pkg::BR_LTU;
                3'd7:    c.branch = rv_pkg::BR_GEU;
                default: ok = 1'b0;
            endcase
        end
        rv_pkg::OPC_JALR: begin
            c.alu_op   = rv_pkg::ALU_LINK;
            c.imm_kind = rv_pkg::IMM_I;
            c.jalr     = 1'b1;
            c.wb.we    = 1'b1;
            c.rs1_used = 1'b1;
        end
        rv_pkg::OPC_JAL: begin
            c.jal   = 1'b1;
            c.wb.we = 1'b1;
        end
        rv_pkg::OPC_LUI: begin
            c.imm_kind = rv_pkg::IMM_U;
            c.wb.we    = 1'b1;
        end
        rv_pkg::OPC_AUIPC: begin
            c.alu_op   = rv_pkg::ALU_ADD;
            c.imm_kind = rv_pkg::IMM_U;
            c.auipc    = 1'b1;
            c.wb.we    = 1'b1;
        end
        default: ok = 1'b0;
    endcase
    c.wb.rd = c.wb.we ? w[11:7] : 5'd0;
    c.rs1   = c.rs1_used ? w[19:15] : 5'd0;
    c.rs2   = c.rs2_used ? w[24:20] : 5'd0;
    if (!ok) begin
        c         = '0;
        c.illegal = 1'b1;
    end
    return c;
endfunction

// EX keeps everything except the source fields
function automatic rv_pkg::ex_issue_t to_ex_issue(logic [31:0] pc, rv_pkg::id_ctrl_t c);
    return {pc, c.alu_op, c.imm_kind, c.branch, c.jal, c.jalr, c.auipc, c.illegal, c.mem, c.wb};
endfunction

function automatic rv_pkg::mem_req_t to_mem_req(logic [31:0] pc, rv_pkg::id_ctrl_t c);
    return {pc, c.mem, c.wb};
endfunction

// Load in EX feeding a source of the next word in ID
function automatic logic load_use_hit(rv_pkg::id_ctrl_t ld, rv_pkg::id_ctrl_t nxt);
    logic [4:0] rd;
    rd = ld.wb.rd;
    return ld.mem.load && (rd != 5'd0)
        && ((nxt.rs1_used && (nxt.rs1 == rd)) || (nxt.rs2_used && (nxt.rs2 == rd)));
endfunction

`endif

// ==== bench/tb_rv_ctrl_pipeline.sv ====
// Testbench for the RV32I control path with random instruction stream and stage scoreboards
`timescale 1ns/1ps
`default_nettype none

module tb_rv_ctrl_pipeline;

    `include "rv_ref_model.svh"

    localparam logic [31:0] PC_RESET        = 32'h0000_1000;
    localparam int          NUM_WORDS       = 400;
    localparam int          CYCLES_PER_WORD = 10;   // Input gaps plus stalls, with margin
    localparam int          TIMEOUT_CYCLES  = NUM_WORDS * CYCLES_PER_WORD;

    logic                clk = 1'b0;
    logic                reset;
    logic                inst_valid;
    logic [31:0]         inst;
    logic                inst_ready;
    logic                ex_valid;
    rv_pkg::ex_issue_t   ex_issue;
    logic                mem_valid;
    rv_pkg::mem_req_t    mem_req;
    logic                wb_valid;
    rv_pkg::wb_ctrl_t    wb;

    rv_pkg::ex_issue_t   ex_q[$];
    rv_pkg::mem_req_t    mem_q[$];
    rv_pkg::wb_ctrl_t    wb_q[$];
    rv_pkg::id_ctrl_t    dec;
    rv_pkg::id_ctrl_t    prev_dec;
    logic                have_prev = 1'b0;
    logic                hit;
    logic [31:0]         pc_exp;
    int                  cycle_count  = 0;
    int                  prev_leave   = 0;   // Edge at which the last word left ID
    int                  accepted     = 0;
    int                  wb_done      = 0;
    int                  stall_seen   = 0;
    int                  stall_expect = 0;
    int                  sent;

    rv_ctrl_pipeline #(
        .PC_RESET (PC_RESET)
    ) u_rv_ctrl_pipeline (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .ex_valid   (ex_valid),
        .ex_issue   (ex_issue),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_ex(input rv_pkg::ex_issue_t got, input rv_pkg::ex_issue_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch ex_issue: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_mem(input rv_pkg::mem_req_t got, input rv_pkg::mem_req_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch mem_req: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_wb(input rv_pkg::wb_ctrl_t got, input rv_pkg::wb_ctrl_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch wb: got %h expected %h", got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string name);
        if (got != exp) begin
            abort_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Registers limited to x0..x3 so load-use pairs come up often
    function automatic logic [31:0] make_word();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        rd  = 5'($urandom_range(3, 0));
        rs1 = 5'($urandom_range(3, 0));
        rs2 = 5'($urandom_range(3, 0));
        f3  = 3'($urandom_range(7, 0));
        imm = 12'($urandom());
        case ($urandom_range(11, 0))
            0:       return {1'b0, imm[5], 5'b0, rs2, rs1, f3, rd, rv_pkg::OPC_R};
            1:       return {imm, rs1, f3, rd, rv_pkg::OPC_I};
            2, 3:    return {imm, rs1, f3, rd, rv_pkg::OPC_LOAD};
            4:       return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_STORE};
            5:       return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OPC_BRANCH};
            6:       return {imm, rs1, 3'b000, rd, rv_pkg::OPC_JALR};
            7:       return {imm, imm[7:0], rd, rv_pkg::OPC_JAL};
            8:       return {imm, imm[7:0], rd, rv_pkg::OPC_LUI};
            9:       return {imm, imm[7:0], rd, rv_pkg::OPC_AUIPC};
            10:      return 32'h0;
            default: return {imm, imm[7:0], rd, imm[0] ? 7'b0001011 : 7'b1111111};
        endcase
    endfunction

    // Scoreboard, stall bookkeeping and timeout
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            abort_run($sformatf("Timeout after %0d cycles, %0d of %0d words written back",
                                cycle_count, wb_done, NUM_WORDS));
        end else if (!reset) begin
            if (!inst_ready) begin
                stall_seen++;
            end
            if (inst_valid && inst_ready) begin
                dec = ref_decode(inst);
                hit = have_prev && (cycle_count == prev_leave) && load_use_hit(prev_dec, dec);
                if (hit) begin
                    stall_expect++;
                end
                prev_leave = cycle_count + (hit ? 2 : 1);
                pc_exp     = PC_RESET + 32'(accepted * 4);
                ex_q.push_back(to_ex_issue(pc_exp, dec));
                mem_q.push_back(to_mem_req(pc_exp, dec));
                wb_q.push_back(dec.wb);
                prev_dec  = dec;
                have_prev = 1'b1;
                accepted++;
            end
            if (ex_valid === 1'b1) begin
                if (ex_q.size() == 0) abort_run("EX valid with no accepted word pending");
                else check_ex(ex_issue, ex_q.pop_front());
            end
            if (mem_valid === 1'b1) begin
                if (mem_q.size() == 0) abort_run("MEM valid with no accepted word pending");
                else check_mem(mem_req, mem_q.pop_front());
            end
            if (wb_valid === 1'b1) begin
                if (wb_q.size() == 0) begin
                    abort_run("WB valid with no accepted word pending");
                end else begin
                    check_wb(wb, wb_q.pop_front());
                    wb_done++;
                end
            end
        end
    end

    initial begin
        reset      = 1'b1;
        inst_valid = 1'b1;            // Offered during reset, must not enter the pipeline
        inst       = 32'h0000_a083;   // lw x1, 0(x1), stalls on itself if it leaks
        void'($urandom(56530));
        repeat (8) @(posedge clk);
        reset      <= 1'b0;
        inst_valid <= 1'b0;
        @(posedge clk);
        check_flag(inst_ready, 1'b1, "inst_ready");
        check_flag(ex_valid, 1'b0, "ex_valid");
        check_flag(mem_valid, 1'b0, "mem_valid");
        check_flag(wb_valid, 1'b0, "wb_valid");

        sent = 0;
        while (sent < NUM_WORDS) begin
            if (inst_valid && inst_ready) begin
                sent++;
            end
            if (sent == NUM_WORDS) begin
                inst_valid <= 1'b0;
            end else if (!inst_valid || inst_ready) begin
                if ($urandom_range(3, 0) != 0) begin   // Valid about 3 cycles in 4
                    inst_valid <= 1'b1;
                    inst       <= make_word();
                end else begin
                    inst_valid <= 1'b0;
                    inst       <= $urandom();   // Junk while idle
                end
            end
            if (sent < NUM_WORDS) begin
                @(posedge clk);
            end
        end

        wait (wb_done == NUM_WORDS);
        repeat (4) @(posedge clk);   // Idle tail, nothing more may come out
        check_count(stall_seen, stall_expect, "stall cycles");
        if (ex_q.size() != 0 || mem_q.size() != 0 || wb_q.size() != 0) begin
            abort_run("Accepted words still pending after the last write-back");
        end else if (stall_expect == 0) begin
            abort_run("Random stream produced no load-use hazard");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+bench
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decoder.sv
hw/rv_hazard_unit.sv
hw/rv_stage_regs.sv
hw/rv_ctrl_pipeline.sv
bench/tb_rv_ctrl_pipeline.sv

// ==== hw/rv_ctrl_pipeline.sv ====
// Top level of the five-stage RV32I control path
`timescale 1ns/1ps
`default_nettype none

module rv_ctrl_pipeline #(
    parameter logic [31:0] PC_RESET = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  logic [rv_pkg::INSTR_W-1:0] inst,
    output logic                       inst_ready,
    output logic                       ex_valid,
    output rv_pkg::ex_issue_t          ex_issue,
    output logic                       mem_valid,
    output rv_pkg::mem_req_t           mem_req,
    output logic                       wb_valid,
    output rv_pkg::wb_ctrl_t           wb
);

    logic                       id_valid;
    logic [rv_pkg::INSTR_W-1:0] id_inst;
    logic [rv_pkg::INSTR_W-1:0] id_pc;
    rv_pkg::id_ctrl_t           id_ctrl;
    logic                       stall;

    rv_fetch #(
        .PC_RESET (PC_RESET)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .inst_ready (inst_ready),
        .id_valid   (id_valid),
        .id_inst    (id_inst),
        .id_pc      (id_pc)
    );

    rv_decoder u_decoder (
        .inst (id_inst),
        .ctrl (id_ctrl)
    );

    // Load and destination come straight from the EX slot
    rv_hazard_unit u_hazard_unit (
        .id_valid (id_valid),
        .id_ctrl  (id_ctrl),
        .ex_valid (ex_valid),
        .ex_load  (ex_issue.mem.load),
        .ex_rd    (ex_issue.wb.rd),
        .stall    (stall)
    );

    rv_stage_regs u_stage_regs (
        .clk       (clk),
        .reset     (reset),
        .id_valid  (id_valid),
        .id_pc     (id_pc),
        .id_ctrl   (id_ctrl),
        .stall     (stall),
        .ex_valid  (ex_valid),
        .ex_issue  (ex_issue),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .wb_valid  (wb_valid),
        .wb        (wb)
    );

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
// Instruction decoder from RV32I word to ID control bundle
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic [rv_pkg::INSTR_W-1:0] inst,
    output rv_pkg::id_ctrl_t           ctrl
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic             alt;    // funct7 bit 30, SUB and SRA select
    logic             bad;
    rv_pkg::id_ctrl_t c;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    always_comb begin
        c   = '0;
        bad = 1'b0;

        if (inst != '0) begin
            case (opcode)
                rv_pkg::OPC_R: begin
                    c.wb.we    = 1'b1;
                    c.rs1_used = 1'b1;
                    c.rs2_used = 1'b1;
                    case (funct3)
                        3'b000:  c.alu_op = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        3'b001:  c.alu_op = rv_pkg::ALU_SLL;
                        3'b010:  c.alu_op = rv_pkg::ALU_SLT;
                        3'b011:  c.alu_op = rv_pkg::ALU_SLTU;
                        3'b100:  c.alu_op = rv_pkg::ALU_XOR;
                        3'b101:  c.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        3'b110:  c.alu_op = rv_pkg::ALU_OR;
                        default: c.alu_op = rv_pkg::ALU_AND;
                    endcase
                end
                rv_pkg::OPC_I: begin
                    c.imm_kind = rv_pkg::IMM_I;
                    c.wb.we    = 1'b1;
                    c.rs1_used = 1'b1;
                    case (funct3)
                        3'b000:  c.alu_op = rv_pkg::ALU_ADD;
                        3'b001:  c.alu_op = rv_pkg::ALU_SLL;
                        3'b010:  c.alu_op = rv_pkg::ALU_SLT;
                        3'b011:  c.alu_op = rv_pkg::ALU_SLTU;
                        3'b100:  c.alu_op = rv_pkg::ALU_XOR;
                        3'b101:  c.alu_op = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        3'b110:  c.alu_op = rv_pkg::ALU_OR;
                        default: c.alu_op = rv_pkg::ALU_AND;
                    endcase
                end
                rv_pkg::OPC_JALR: begin
                    c.alu_op   = rv_pkg::ALU_LINK;
                    c.imm_kind = rv_pkg::IMM_I;
                    c.jalr     = 1'b1;
                    c.wb.we    = 1'b1;
                    c.rs1_used = 1'b1;
                end
                rv_pkg::OPC_LOAD: begin
                    c.alu_op   = rv_pkg::ALU_ADD;   // Address is rs1 plus offset
                    c.imm_kind = rv_pkg::IMM_I;
                    c.mem.en   = 1'b1;
                    c.mem.load = 1'b1;
                    c.wb.we    = 1'b1;
                    c.rs1_used = 1'b1;
                    case (funct3)
                        3'b000:  {c.mem.size, c.mem.sext} = {rv_pkg::SIZE_BYTE, 1'b1};
                        3'b001:  {c.mem.size, c.mem.sext} = {rv_pkg::SIZE_HALF, 1'b1};
                        3'b010:  c.mem.size = rv_pkg::SIZE_WORD;
                        3'b100:  c.mem.size = rv_pkg::SIZE_BYTE;
                        3'b101:  c.mem.size = rv_pkg::SIZE_HALF;
                        default: bad = 1'b1;
                    endcase
                end
                rv_pkg::OPC_STORE: begin
                    c.alu_op    = rv_pkg::ALU_ADD;
                    c.imm_kind  = rv_pkg::IMM_S;
                    c.mem.en    = 1'b1;
                    c.mem.write = 1'b1;
                    c.rs1_used  = 1'b1;
                    c.rs2_used  = 1'b1;
                    case (funct3)
                        3'b000:  c.mem.size = rv_pkg::SIZE_BYTE;
                        3'b001:  c.mem.size = rv_pkg::SIZE_HALF;
                        3'b010:  c.mem.size = rv_pkg::SIZE_WORD;
                        default: bad = 1'b1;
                    endcase
                end
                rv_pkg::OPC_BRANCH: begin
                    c.rs1_used = 1'b1;
                    c.rs2_used = 1'b1;
                    // Compare op feeds the condition check in EX
                    case (funct3)
                        3'b000:  {c.alu_op, c.branch} = {rv_pkg::ALU_SUB, rv_pkg::BR_EQ};
                        3'b001:  {c.alu_op, c.branch} = {rv_pkg::ALU_SUB, rv_pkg::BR_NE};
                        3'b100:  {c.alu_op, c.branch} = {rv_pkg::ALU_SLT, rv_pkg::BR_LT};
                        3'b101:  {c.alu_op, c.branch} = {rv_pkg::ALU_SLT, rv_pkg::BR_GE};
                        3'b110:  {c.alu_op, c.branch} = {rv_pkg::ALU_SLTU, rv_pkg::BR_LTU};
                        3'b111:  {c.alu_op, c.branch} = {rv_pkg::ALU_SLTU, rv_pkg::BR_GEU};
                        default: bad = 1'b1;
                    endcase
                end
                rv_pkg::OPC_LUI: begin
                    c.alu_op   = rv_pkg::ALU_PASS_B;
                    c.imm_kind = rv_pkg::IMM_U;
                    c.wb.we    = 1'b1;
                end
                rv_pkg::OPC_AUIPC: begin
                    c.alu_op   = rv_pkg::ALU_ADD;   // PC plus upper immediate
                    c.imm_kind = rv_pkg::IMM_U;
                    c.auipc    = 1'b1;
                    c.wb.we    = 1'b1;
                end
                rv_pkg::OPC_JAL: begin
                    c.jal   = 1'b1;
                    c.wb.we = 1'b1;
                end
                default: bad = 1'b1;
            endcase
        end

        // Register fields only where the format has them
        c.wb.rd = c.wb.we ? inst[11:7] : '0;
        c.rs1   = c.rs1_used ? inst[19:15] : '0;
        c.rs2   = c.rs2_used ? inst[24:20] : '0;

        if (bad) begin
            ctrl         = '0;
            ctrl.illegal = 1'b1;
        end else begin
            ctrl = c;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_fetch.sv ====
// PC register, instruction input handshake and IF/ID register
`timescale 1ns/1ps
`default_nettype none

module rv_fetch #(
    parameter logic [31:0] PC_RESET = 32'h0
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       inst_valid,
    input  logic [rv_pkg::INSTR_W-1:0] inst,
    input  logic                       stall,
    output logic                       inst_ready,
    output logic                       id_valid,
    output logic [rv_pkg::INSTR_W-1:0] id_inst,
    output logic [rv_pkg::INSTR_W-1:0] id_pc
);

    logic [rv_pkg::INSTR_W-1:0] pc;
    logic                       accept;

    assign inst_ready = ~stall;
    assign accept     = inst_valid & inst_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= PC_RESET;
            id_valid <= 1'b0;
        end else if (!stall) begin
            id_valid <= accept;   // Empty slot when nothing arrives
            if (accept) begin
                pc <= pc + 32'd4;   // No redirect, sequential only
            end
        end
    end

    // Word and PC payload
    always_ff @(posedge clk) begin
        if (accept) begin
            id_inst <= inst;
            id_pc   <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_hazard_unit.sv ====
// Load-use hazard detection between the ID and EX slots
`timescale 1ns/1ps
`default_nettype none

module rv_hazard_unit (
    input  logic                          id_valid,
    input  rv_pkg::id_ctrl_t              id_ctrl,
    input  logic                          ex_valid,
    input  logic                          ex_load,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                          stall
);

    logic rs1_hit;
    logic rs2_hit;

    assign rs1_hit = id_ctrl.rs1_used && (id_ctrl.rs1 == ex_rd);
    assign rs2_hit = id_ctrl.rs2_used && (id_ctrl.rs2 == ex_rd);

    // x0 never carries a dependence
    assign stall = id_valid && ex_valid && ex_load && (ex_rd != '0) && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
// Widths, opcode constants, control enums and stage bundle structs for the RV32I control path
`default_nettype none

package rv_pkg;

    localparam int INSTR_W    = 32;   // Instruction and PC width
    localparam int REG_ADDR_W = 5;

    // Major opcodes, one per format
    localparam logic [6:0] OPC_R      = 7'b0110011;
    localparam logic [6:0] OPC_I      = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU_PASS_B = 4'd0,   // Operand B straight through, LUI and JAL
        ALU_ADD    = 4'd2,
        ALU_SUB    = 4'd3,
        ALU_LINK   = 4'd4,   // Return address for JALR
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_AND    = 4'd10,
        ALU_OR     = 4'd11,
        ALU_XOR    = 4'd12
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_U
    } imm_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_e;

    typedef struct packed {
        logic      en;      // Data memory access
        logic      write;
        logic      load;
        mem_size_e size;
        logic      sext;    // Sign extend loaded byte or half
    } mem_ctrl_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
    } wb_ctrl_t;

    typedef struct packed {
        alu_op_e               alu_op;
        imm_kind_e             imm_kind;
        branch_e               branch;
        logic                  jal;
        logic                  jalr;
        logic                  auipc;
        logic                  illegal;
        mem_ctrl_t             mem;
        wb_ctrl_t              wb;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs1_used;
        logic                  rs2_used;
    } id_ctrl_t;

    // ID bundle without source fields, tagged with its PC
    typedef struct packed {
        logic [INSTR_W-1:0] pc;
        alu_op_e            alu_op;
        imm_kind_e          imm_kind;
        branch_e            branch;
        logic               jal;
        logic               jalr;
        logic               auipc;
        logic               illegal;
        mem_ctrl_t          mem;
        wb_ctrl_t           wb;
    } ex_issue_t;

    typedef struct packed {
        logic [INSTR_W-1:0] pc;
        mem_ctrl_t          mem;
        wb_ctrl_t           wb;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== hw/rv_stage_regs.sv ====
// ID/EX, EX/MEM and MEM/WB control registers with bubble insertion
`timescale 1ns/1ps
`default_nettype none

module rv_stage_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       id_valid,
    input  logic [rv_pkg::INSTR_W-1:0] id_pc,
    input  rv_pkg::id_ctrl_t           id_ctrl,
    input  logic                       stall,
    output logic                       ex_valid,
    output rv_pkg::ex_issue_t          ex_issue,
    output logic                       mem_valid,
    output rv_pkg::mem_req_t           mem_req,
    output logic                       wb_valid,
    output rv_pkg::wb_ctrl_t           wb
);

    rv_pkg::ex_issue_t issue_d;   // ID bundle with source fields dropped
    rv_pkg::mem_req_t  req_d;

    always_comb begin
        issue_d.pc       = id_pc;
        issue_d.alu_op   = id_ctrl.alu_op;
        issue_d.imm_kind = id_ctrl.imm_kind;
        issue_d.branch   = id_ctrl.branch;
        issue_d.jal      = id_ctrl.jal;
        issue_d.jalr     = id_ctrl.jalr;
        issue_d.auipc    = id_ctrl.auipc;
        issue_d.illegal  = id_ctrl.illegal;
        issue_d.mem      = id_ctrl.mem;
        issue_d.wb       = id_ctrl.wb;
    end

    always_comb begin
        req_d.pc  = ex_issue.pc;
        req_d.mem = ex_issue.mem;
        req_d.wb  = ex_issue.wb;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            ex_valid  <= id_valid & ~stall;   // Bubble while ID holds
            mem_valid <= ex_valid;
            wb_valid  <= mem_valid;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        ex_issue <= stall ? '0 : issue_d;
        mem_req  <= req_d;
        wb       <= mem_req.wb;
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_rv_ctrl_pipeline \
    -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log \
    && echo "simulation PASS" \
    || { echo "simulation FAIL, see sim.log"; exit 1; }
